// ==== dv/resetSubsystemTb.sv ====
// Reset subsystem testbench
// Directed tests for the start-up sequence, barrier stalls, restart and async reset

`timescale 1ns/1ps
`default_nettype none

module resetSubsystemTb
    import resetPkg::*;
();

    function automatic int maxSettle();
        int m;
        m = 0;
        for (int i = 0; i < numDomains; i++) begin
            if (int'(domainSettle[i]) > m) begin
                m = int'(domainSettle[i]);
            end
        end
        return m;
    endfunction

    localparam int settleMax = maxSettle();
    // Worst case of one sequence with clkEn held high, capture stage included
    localparam int seqLen = 8 + resetWaitCycles + operationalWaitCycles +
                            initializeWaitCycles + 2 * (settleMax + 4);
    // Reset check, two plain runs, random gaps at up to 4x, restart and async reset runs
    localparam int testCycles = 10 + 2 * (seqLen + 10) + 4 * (seqLen + 10) +
                                2 * (2 * seqLen + 10);
    localparam int timeoutCycles = 2 * testCycles;

    logic       clk;
    logic       async_rst_in;
    logic       clkEn;
    logic       restart;
    domainVec_t domainRst;
    domainVec_t domainRun;
    logic       syncRstOut;
    logic       clkEnOut;
    logic       initOut;
    logic       seqDone;

    int          valueErrors = 0;
    int          seqErrors = 0;
    int          cycleCount = 0;
    logic        randomGaps = 1'b0;
    logic [31:0] lcgState = 32'ha997;

    // Pulse bookkeeping in enabled cycles
    int enCount;
    int syncRstNum;
    int clkEnNum;
    int initNum;
    int syncRstAt;
    int clkEnAt;
    int initAt;

    resetSubsystem resetSubsystem_i (
        .clk          (clk),
        .async_rst_in (async_rst_in),
        .clkEn        (clkEn),
        .restart      (restart),
        .domainRst    (domainRst),
        .domainRun    (domainRun),
        .syncRstOut   (syncRstOut),
        .clkEnOut     (clkEnOut),
        .initOut      (initOut),
        .seqDone      (seqDone)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Error: run did not finish within %0d cycles", timeoutCycles);
            $display("Errors: value %0d, sequence %0d", valueErrors, seqErrors);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
        valueErrors++;
    endtask

    task automatic clearMonitor();
        enCount    = 0;
        syncRstNum = 0;
        clkEnNum   = 0;
        initNum    = 0;
        syncRstAt  = 0;
        clkEnAt    = 0;
        initAt     = 0;
    endtask

    // Called at the falling edge, where all outputs are settled
    task automatic sampleOutputs();
        if (!clkEn) begin
            if (syncRstOut || clkEnOut || initOut) begin
                $display("Error: pulse seen on a cycle without clock enable");
                seqErrors++;
            end
        end
        else begin
            enCount++;
            if (restart && (syncRstOut || clkEnOut || initOut)) begin
                $display("Error: pulse seen on the restart cycle");
                seqErrors++;
            end
            // Domains stay in reset until the operational pulse
            if (syncRstNum == 1 && clkEnNum == 0 && domainRst !== '1) begin
                reportMismatch("domainRst", 32'(domainVec_t'('1)), 32'(domainRst));
            end
            if (syncRstOut) begin
                if (clkEnNum != 0 || initNum != 0) begin
                    $display("Error: syncRstOut pulsed after a later phase pulse");
                    seqErrors++;
                end
                syncRstNum++;
                syncRstAt = enCount;
            end
            if (clkEnOut) begin
                if (syncRstNum != 1 || initNum != 0) begin
                    $display("Error: clkEnOut pulsed out of order");
                    seqErrors++;
                end
                clkEnNum++;
                clkEnAt = enCount;
            end
            if (initOut) begin
                if (clkEnNum != 1) begin
                    $display("Error: initOut pulsed before clkEnOut");
                    seqErrors++;
                end
                initNum++;
                initAt = enCount;
            end
        end
    endtask

    task automatic tick(input logic restartIn);
        @(posedge clk);
        restart <= restartIn;
        if (randomGaps) begin
            lcgState = lcgNext(lcgState);
            clkEn <= (lcgState[17:16] != 2'b00);
        end
        else begin
            clkEn <= 1'b1;
        end
        @(negedge clk);
        sampleOutputs();
    endtask

    task automatic applyReset();
        @(posedge clk);
        async_rst_in <= 1'b1;
        restart      <= 1'b0;
        clkEn        <= 1'b1;
        repeat (3) @(posedge clk);
        async_rst_in <= 1'b0;
    endtask

    task automatic checkIdle();
        if (domainRst !== '1) begin
            reportMismatch("domainRst", 32'(domainVec_t'('1)), 32'(domainRst));
        end
        if (domainRun !== '0) begin
            reportMismatch("domainRun", 32'h0, 32'(domainRun));
        end
        if (syncRstOut !== 1'b0) begin
            reportMismatch("syncRstOut", 32'h0, 32'(syncRstOut));
        end
        if (clkEnOut !== 1'b0) begin
            reportMismatch("clkEnOut", 32'h0, 32'(clkEnOut));
        end
        if (initOut !== 1'b0) begin
            reportMismatch("initOut", 32'h0, 32'(initOut));
        end
        if (seqDone !== 1'b0) begin
            reportMismatch("seqDone", 32'h0, 32'(seqDone));
        end
    endtask

    // Runs to seqDone, watches a few more cycles, then checks counts and spacing
    task automatic finishSequence();
        while (!seqDone) begin
            tick(1'b0);
        end
        repeat (6) tick(1'b0);
        if (syncRstNum != 1) begin
            reportMismatch("syncRstOut pulses", 32'h1, 32'(syncRstNum));
        end
        if (clkEnNum != 1) begin
            reportMismatch("clkEnOut pulses", 32'h1, 32'(clkEnNum));
        end
        if (initNum != 1) begin
            reportMismatch("initOut pulses", 32'h1, 32'(initNum));
        end
        if (clkEnAt - syncRstAt < operationalWaitCycles + settleMax) begin
            $display("Error: clkEnOut came %0d enabled cycles after syncRstOut, minimum %0d",
                     clkEnAt - syncRstAt, operationalWaitCycles + settleMax);
            seqErrors++;
        end
        if (initAt - clkEnAt < initializeWaitCycles + settleMax) begin
            $display("Error: initOut came %0d enabled cycles after clkEnOut, minimum %0d",
                     initAt - clkEnAt, initializeWaitCycles + settleMax);
            seqErrors++;
        end
        if (seqDone !== 1'b1) begin
            reportMismatch("seqDone", 32'h1, 32'(seqDone));
        end
        if (domainRun !== '1) begin
            reportMismatch("domainRun", 32'(domainVec_t'('1)), 32'(domainRun));
        end
        if (domainRst !== '0) begin
            reportMismatch("domainRst", 32'h0, 32'(domainRst));
        end
    endtask

    task automatic testAfterReset();
        applyReset();
        tick(1'b0);
        checkIdle();
    endtask

    task automatic testFullSequence();
        applyReset();
        clearMonitor();
        finishSequence();
    endtask

    // Domain reset drops only one enabled cycle after the operational pulse
    task automatic testSlowestDomain();
        tick(1'b1);
        clearMonitor();
        while (clkEnNum == 0) begin
            tick(1'b0);
        end
        tick(1'b0);
        if (domainRst !== '0) begin
            reportMismatch("domainRst", 32'h0, 32'(domainRst));
        end
        if (domainRun !== '0) begin
            reportMismatch("domainRun", 32'h0, 32'(domainRun));
        end
        finishSequence();
    endtask

    task automatic testRandomGaps();
        randomGaps = 1'b1;
        applyReset();
        clearMonitor();
        finishSequence();
        randomGaps = 1'b0;
    endtask

    task automatic testRestart();
        applyReset();
        clearMonitor();
        while (syncRstNum == 0) begin
            tick(1'b0);
        end
        // Middle of the operational count
        while (enCount < syncRstAt + settleMax + 3 + operationalWaitCycles / 2) begin
            tick(1'b0);
        end
        if (clkEnNum != 0) begin
            $display("Error: operational phase ended before the restart point");
            seqErrors++;
        end
        tick(1'b1);
        clearMonitor();
        tick(1'b0);
        checkIdle();
        // Second restart lands on the cycle of the reset pulse
        repeat (resetWaitCycles - 1) tick(1'b0);
        if (syncRstNum != 0) begin
            $display("Error: syncRstOut came before the reset phase ended");
            seqErrors++;
        end
        tick(1'b1);
        clearMonitor();
        finishSequence();
    endtask

    task automatic testAsyncReset();
        applyReset();
        clearMonitor();
        // Into the operational settle, where domainRst is low
        while (clkEnNum == 0) begin
            tick(1'b0);
        end
        repeat (10) tick(1'b0);
        applyReset();
        tick(1'b0);
        checkIdle();
        clearMonitor();
        finishSequence();
    endtask

    initial begin
        async_rst_in = 1'b1;
        clkEn        = 1'b0;
        restart      = 1'b0;
        clearMonitor();
        testAfterReset();
        testFullSequence();
        testSlowestDomain();
        testRandomGaps();
        testRestart();
        testAsyncReset();
        $display("Errors: value %0d, sequence %0d", valueErrors, seqErrors);
        if (valueErrors == 0 && seqErrors == 0) begin
            $display("Test OK");
        end
        else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/domainAgent.sv ====
// Domain agent
// Holds one domain's reset and run levels and reports ready after its settle time

`timescale 1ns/1ps
`default_nettype none

module domainAgent
    import resetPkg::*;
#(
    parameter settleCount_t settleCycles = 8'd1
)(
    input  wire         clk,
    input  wire         async_rst_in,
    input  wire         restart,
    input  domainCtrl_t ctrl,
    output logic        domainRst,
    output logic        domainRun,
    output logic        ready
);

    agentState_t  state;
    settleCount_t count;
    logic         settleDone;

    assign settleDone = ctrl.stepEn && (count == settleCycles - 1'b1);

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            state <= held;
            count <= '0;
            ready <= 1'b0;
        end
        else if (ctrl.stepEn) begin
            if (restart) begin
                state <= held;
                count <= '0;
                ready <= 1'b0;
            end
            else if (ctrl.syncRst) begin
                state <= resetSettle;
                count <= '0;
                ready <= 1'b0;
            end
            else begin
                case (state)
                    resetSettle: begin
                        if (settleDone) begin
                            state <= resetReady;
                            ready <= 1'b1;
                        end
                        else begin
                            count <= count + 1'b1;
                        end
                    end
                    resetReady: begin
                        if (ctrl.clkEnable) begin
                            state <= operSettle;
                            count <= '0;
                            ready <= 1'b0;
                        end
                    end
                    operSettle: begin
                        if (ctrl.init) begin
                            state <= running;
                            ready <= 1'b0;
                        end
                        // Count stops once ready is up
                        else if (!ready) begin
                            if (settleDone) begin
                                ready <= 1'b1;
                            end
                            else begin
                                count <= count + 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Domain stays in reset until the operational phase starts
    assign domainRst = (state == held) || (state == resetSettle) || (state == resetReady);
    assign domainRun = (state == running);

endmodule

`default_nettype wire

// ==== hdl/resetPkg.sv ====
// Reset subsystem package
// Phase lengths, domain table, shared vector types, broadcast struct and FSM encodings

`default_nettype none

package resetPkg;

    // Phase lengths in enabled cycles, kept short for simulation
    localparam int resetWaitCycles       = 40;
    localparam int operationalWaitCycles = 30;
    localparam int initializeWaitCycles  = 20;

    localparam int numDomains = 3;

    localparam int longestPhase =
        (resetWaitCycles > operationalWaitCycles) ?
        ((resetWaitCycles > initializeWaitCycles) ? resetWaitCycles : initializeWaitCycles) :
        ((operationalWaitCycles > initializeWaitCycles) ? operationalWaitCycles :
                                                          initializeWaitCycles);
    localparam int cycleWidth = $clog2(longestPhase + 1);

    typedef logic [cycleWidth-1:0] cycleCount_t;
    typedef logic [7:0]            settleCount_t;
    typedef logic [numDomains-1:0] domainVec_t;

    // Last counter value of each phase
    localparam cycleCount_t resetLast = cycleCount_t'(resetWaitCycles - 1);
    localparam cycleCount_t operLast  = cycleCount_t'(operationalWaitCycles - 1);
    localparam cycleCount_t initLast  = cycleCount_t'(initializeWaitCycles - 1);

    // Settle cycles per domain, entry i belongs to agent i
    localparam settleCount_t [numDomains-1:0] domainSettle = {8'd9, 8'd12, 8'd5};

    // Broadcast from the sequencer to every agent
    typedef struct packed {
        logic syncRst;
        logic clkEnable;
        logic init;
        logic stepEn;
    } domainCtrl_t;

    typedef enum logic [2:0] {
        idle,
        countReset,
        waitReset,
        countOper,
        waitOper,
        countInit,
        done
    } seqState_t;

    typedef enum logic [2:0] {
        held,
        resetSettle,
        resetReady,
        operSettle,
        running
    } agentState_t;

endpackage

`default_nettype wire

// ==== hdl/resetSequencer.sv ====
// Start-up sequencer
// Detects reset release or restart, counts the three phases and stalls at two barriers

`timescale 1ns/1ps
`default_nettype none

module resetSequencer
    import resetPkg::*;
(
    input  wire         clk,
    input  wire         async_rst_in,
    input  wire         clkEn,
    input  wire         restart,
    input  wire         syncClear,
    output domainCtrl_t ctrl,
    output logic        syncWait,
    output logic        seqDone
);

    logic [7:0]  rstCapture;
    logic        asyncTrigger;
    logic        restartQ;
    logic        restartEnd;
    logic        startEvent;
    seqState_t   state;
    cycleCount_t count;
    cycleCount_t phaseLast;
    logic        counting;
    logic        phaseEnd;
    logic        initLimit;

    // Fills with ones on enabled cycles after the reset release
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            rstCapture <= '0;
        end
        else if (clkEn) begin
            rstCapture <= {rstCapture[6:0], 1'b1};
        end
    end

    // Single enabled cycle where bit 6 is set but bit 7 not yet
    assign asyncTrigger = rstCapture[6] && !rstCapture[7];

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            restartQ <= 1'b0;
        end
        else if (clkEn) begin
            restartQ <= restart;
        end
    end

    assign restartEnd = restartQ && !restart;
    assign startEvent = (state == idle) && (asyncTrigger || restartEnd);

    always_comb begin
        case (state)
            countReset: phaseLast = resetLast;
            countOper:  phaseLast = operLast;
            default:    phaseLast = initLast;
        endcase
    end

    assign counting = (state == countReset) || (state == countOper) || (state == countInit);
    // Restart suppresses every pulse on its cycle
    assign phaseEnd = clkEn && !restart && counting && (count == phaseLast);

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            state <= idle;
            count <= '0;
        end
        else if (clkEn) begin
            if (restart) begin
                state <= idle;
                count <= '0;
            end
            else begin
                case (state)
                    idle: begin
                        if (startEvent) begin
                            state <= countReset;
                            count <= '0;
                        end
                    end
                    countReset: begin
                        if (phaseEnd) begin
                            state <= waitReset;
                        end
                        else begin
                            count <= count + 1'b1;
                        end
                    end
                    // Counter frozen until every domain is ready
                    waitReset: begin
                        if (syncClear) begin
                            state <= countOper;
                            count <= '0;
                        end
                    end
                    countOper: begin
                        if (phaseEnd) begin
                            state <= waitOper;
                        end
                        else begin
                            count <= count + 1'b1;
                        end
                    end
                    waitOper: begin
                        if (syncClear) begin
                            state <= countInit;
                            count <= '0;
                        end
                    end
                    countInit: begin
                        if (phaseEnd) begin
                            state <= done;
                        end
                        else begin
                            count <= count + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Init fires once per sequence
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            initLimit <= 1'b0;
        end
        else if (clkEn) begin
            if (restart || startEvent) begin
                initLimit <= 1'b0;
            end
            else if (ctrl.init) begin
                initLimit <= 1'b1;
            end
        end
    end

    always_comb begin
        ctrl.syncRst   = phaseEnd && (state == countReset);
        ctrl.clkEnable = phaseEnd && (state == countOper);
        ctrl.init      = phaseEnd && (state == countInit) && !initLimit;
        ctrl.stepEn    = clkEn;
    end

    assign syncWait = (state == waitReset) || (state == waitOper);
    assign seqDone  = (state == done);

endmodule

`default_nettype wire

// ==== hdl/resetSubsystem.sv ====
// Reset subsystem top level
// Sequencer, one agent per clock-enable domain and the barrier between them

`timescale 1ns/1ps
`default_nettype none

module resetSubsystem
    import resetPkg::*;
(
    input  wire        clk,
    input  wire        async_rst_in,
    input  wire        clkEn,
    input  wire        restart,
    output wire        domainVec_t domainRst,
    output wire        domainVec_t domainRun,
    output wire        syncRstOut,
    output wire        clkEnOut,
    output wire        initOut,
    output wire        seqDone
);

    wire domainCtrl_t ctrl;
    wire domainVec_t  ready;
    wire              syncWait;
    wire              syncClear;

    resetSequencer resetSequencer_i (
        .clk          (clk),
        .async_rst_in (async_rst_in),
        .clkEn        (clkEn),
        .restart      (restart),
        .syncClear    (syncClear),
        .ctrl         (ctrl),
        .syncWait     (syncWait),
        .seqDone      (seqDone)
    );

    for (genvar i = 0; i < numDomains; i++) begin : agentGen
        domainAgent #(
            .settleCycles (domainSettle[i])
        ) domainAgent_i (
            .clk          (clk),
            .async_rst_in (async_rst_in),
            .restart      (restart),
            .ctrl         (ctrl),
            .domainRst    (domainRst[i]),
            .domainRun    (domainRun[i]),
            .ready        (ready[i])
        );
    end

    syncBarrier syncBarrier_i (
        .clk          (clk),
        .async_rst_in (async_rst_in),
        .clkEn        (clkEn),
        .restart      (restart),
        .syncWait     (syncWait),
        .ready        (ready),
        .syncClear    (syncClear)
    );

    // Broadcast pulses also leave the subsystem
    assign syncRstOut = ctrl.syncRst;
    assign clkEnOut   = ctrl.clkEnable;
    assign initOut    = ctrl.init;

endmodule

`default_nettype wire

// ==== hdl/syncBarrier.sv ====
// Barrier collector
// Gathers agent ready levels during a wait and returns one clear pulse

`timescale 1ns/1ps
`default_nettype none

module syncBarrier
    import resetPkg::*;
(
    input  wire        clk,
    input  wire        async_rst_in,
    input  wire        clkEn,
    input  wire        restart,
    input  wire        syncWait,
    input  domainVec_t ready,
    output logic       syncClear
);

    domainVec_t seen;

    // Clear goes out once every domain has been seen ready
    assign syncClear = clkEn && syncWait && !restart && (&seen);

    // Sticky per-domain flags, dropped with the clear
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            seen <= '0;
        end
        else if (clkEn) begin
            if (restart || syncClear) begin
                seen <= '0;
            end
            else if (syncWait) begin
                seen <= seen | ready;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the reset subsystem testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing \
    --top-module resetSubsystemTb \
    -f sources.f \
    -o resetSubsystemSim

./obj_dir/resetSubsystemSim | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== sources.f ====
hdl/resetPkg.sv
hdl/resetSequencer.sv
hdl/domainAgent.sv
hdl/syncBarrier.sv
hdl/resetSubsystem.sv
dv/resetSubsystemTb.sv
